//--- verilog/spi_pkg.sv
`default_nettype none

package spi_pkg;

    localparam logic [11:0] ADDR_CR1 = 12'h000;
    localparam logic [11:0] ADDR_CR2 = 12'h004;
    localparam logic [11:0] ADDR_SR  = 12'h008;
    localparam logic [11:0] ADDR_DR  = 12'h00C;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
    } apb_rsp_t;

    // bus view of CR1, bidi/crc and ss bits read as zero
    typedef struct packed {
        logic [19:0] rsvd;
        logic        dff;
        logic [2:0]  rsvd_ss;
        logic        lsbfirst;
        logic        spe;
        logic [2:0]  br;
        logic        mstr;
        logic        cpol;
        logic        cpha;
    } spi_cr1_t;

    typedef struct packed {
        logic [23:0] rsvd;
        logic        txeie;
        logic        rxneie;
        logic [5:0]  rsvd_lo;
    } spi_cr2_t;

    // error flags and chside sit in rsvd_err
    typedef struct packed {
        logic [23:0] rsvd;
        logic        bsy;
        logic [4:0]  rsvd_err;
        logic        rxne;
        logic        txe;
    } spi_sr_t;

    typedef struct packed {
        logic       dff;
        logic       lsbfirst;
        logic       spe;
        logic [2:0] br;
        logic       cpol;
        logic       cpha;
    } spi_cfg_t;

    typedef enum logic [1:0] {
        ST_OFF,
        ST_IDLE,
        ST_START,
        ST_DATA
    } spi_state_e;

    typedef struct packed {
        logic tx_load;
        logic rx_done;
        logic shift_tx;
        logic shift_rx;
        logic cnt_reload;
        logic sck_en;
    } spi_strobe_t;

    typedef struct packed {
        logic cnt_zero;
        logic cnt_half;
        logic bit_zero;
        logic sck_phase;
    } spi_timer_t;

endpackage

`default_nettype wire

//--- verilog/spi_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_regs import spi_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  apb_req_t    apb_req_i,
    output apb_rsp_t    apb_rsp_o,
    output spi_cfg_t    cfg_o,
    output logic        txe_o,
    output logic [15:0] tx_word_o,
    input  spi_strobe_t strobe_i,
    input  logic        bsy_i,
    input  logic [15:0] rx_word_i,
    output logic        irq_o
);

    logic        apb_wr;
    logic        apb_rd;
    spi_cr1_t    cr1_wr;
    spi_cr2_t    cr2_wr;
    spi_cr1_t    cr1_rd;
    spi_cr2_t    cr2_rd;
    spi_sr_t     sr_rd;
    logic [31:0] rdata;
    spi_cfg_t    cfg_q;
    logic        txeie_q;
    logic        rxneie_q;
    logic        txe_q;
    logic        rxne_q;
    logic        bsy_q;
    logic        rx_done_q;
    logic [15:0] tx_buf_q;
    logic [15:0] rx_buf_q;

    // setup phase only
    assign apb_wr = apb_req_i.psel && !apb_req_i.penable && apb_req_i.pwrite;
    assign apb_rd = apb_req_i.psel && !apb_req_i.penable && !apb_req_i.pwrite;
    assign cr1_wr = apb_req_i.pwdata;
    assign cr2_wr = apb_req_i.pwdata;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cfg_q <= '0;
        end else if (apb_wr && apb_req_i.paddr == ADDR_CR1) begin
            cfg_q.cpha <= cr1_wr.cpha;
            cfg_q.cpol <= cr1_wr.cpol;
            cfg_q.spe  <= cr1_wr.spe;
            // frame format locked while enabled
            if (!cfg_q.spe) begin
                cfg_q.br       <= cr1_wr.br;
                cfg_q.lsbfirst <= cr1_wr.lsbfirst;
                cfg_q.dff      <= cr1_wr.dff;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            txeie_q  <= 1'b0;
            rxneie_q <= 1'b0;
        end else if (apb_wr && apb_req_i.paddr == ADDR_CR2) begin
            txeie_q  <= cr2_wr.txeie;
            rxneie_q <= cr2_wr.rxneie;
        end
    end

    // tx buffer, a write with txe low is dropped
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx_buf_q <= '0;
            txe_q    <= 1'b1;
        end else if (apb_wr && apb_req_i.paddr == ADDR_DR && txe_q) begin
            tx_buf_q <= apb_req_i.pwdata[15:0];
            txe_q    <= 1'b0;
        end else if (strobe_i.tx_load) begin
            txe_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rx_done_q <= 1'b0;
            bsy_q     <= 1'b0;
            rx_buf_q  <= '0;
            rxne_q    <= 1'b0;
        end else begin
            rx_done_q <= strobe_i.rx_done;
            bsy_q     <= bsy_i;
            if (rx_done_q) begin
                rx_buf_q <= rx_word_i;
            end
            if (apb_rd && apb_req_i.paddr == ADDR_DR) begin
                rxne_q <= 1'b0;
            end else if (rx_done_q) begin
                rxne_q <= 1'b1;
            end
        end
    end

    always_comb begin
        cr1_rd          = '0;
        cr1_rd.cpha     = cfg_q.cpha;
        cr1_rd.cpol     = cfg_q.cpol;
        cr1_rd.mstr     = 1'b1;
        cr1_rd.br       = cfg_q.br;
        cr1_rd.spe      = cfg_q.spe;
        cr1_rd.lsbfirst = cfg_q.lsbfirst;
        cr1_rd.dff      = cfg_q.dff;
        cr2_rd          = '0;
        cr2_rd.txeie    = txeie_q;
        cr2_rd.rxneie   = rxneie_q;
        sr_rd           = '0;
        sr_rd.txe       = txe_q;
        sr_rd.rxne      = rxne_q;
        sr_rd.bsy       = bsy_q;
        case (apb_req_i.paddr)
            ADDR_CR1: rdata = cr1_rd;
            ADDR_CR2: rdata = cr2_rd;
            ADDR_SR:  rdata = sr_rd;
            ADDR_DR:  rdata = {16'h0000, rx_buf_q};
            default:  rdata = '0;
        endcase
    end

    // valid in the access phase, zero otherwise
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            apb_rsp_o.prdata <= '0;
        end else begin
            apb_rsp_o.prdata <= apb_rd ? rdata : 32'h0;
        end
    end

    assign cfg_o     = cfg_q;
    assign txe_o     = txe_q;
    assign tx_word_o = tx_buf_q;
    assign irq_o     = (txeie_q && txe_q) || (rxneie_q && rxne_q);

endmodule

`default_nettype wire

//--- verilog/spi_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spi_fsm import spi_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  spi_cfg_t    cfg_i,
    input  logic        txe_i,
    input  spi_timer_t  timer_i,
    output spi_strobe_t strobe_o,
    output logic        bsy_o,
    output logic        nss_o
);

    spi_state_e state_q;
    spi_state_e state_d;
    logic       frame_end;
    logic       go;

    assign go        = timer_i.cnt_zero && cfg_i.spe && !txe_i;
    assign frame_end = timer_i.cnt_zero && timer_i.bit_zero;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= ST_OFF;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_OFF: begin
                if (cfg_i.spe) state_d = ST_IDLE;
            end
            ST_IDLE: begin
                if (!cfg_i.spe) state_d = ST_OFF;
                else if (go) state_d = ST_START;
            end
            ST_START: begin
                if (timer_i.cnt_half) state_d = ST_DATA;
            end
            ST_DATA: begin
                // cpha 1 with data pending runs straight on
                if (frame_end && !(cfg_i.cpha && !txe_i)) state_d = ST_IDLE;
            end
            default: state_d = ST_OFF;
        endcase
    end

    always_comb begin
        strobe_o = '0;
        case (state_q)
            ST_OFF: begin
                strobe_o.cnt_reload = cfg_i.spe;
            end
            ST_IDLE: begin
                strobe_o.tx_load    = go;
                strobe_o.cnt_reload = go;
            end
            ST_START: begin
                // half period lead in, cpha 0 takes its first sample here
                strobe_o.cnt_reload = timer_i.cnt_half;
                strobe_o.shift_rx   = !cfg_i.cpha && timer_i.cnt_half;
            end
            ST_DATA: begin
                strobe_o.tx_load    = frame_end && !txe_i && cfg_i.cpha;
                strobe_o.rx_done    = frame_end;
                strobe_o.shift_tx   = cfg_i.cpha ? timer_i.cnt_zero : timer_i.cnt_half;
                strobe_o.shift_rx   = cfg_i.cpha ? timer_i.cnt_half : timer_i.cnt_zero;
                strobe_o.cnt_reload = timer_i.cnt_zero;
                strobe_o.sck_en     = 1'b1;
            end
            default: strobe_o = '0;
        endcase
    end

    assign bsy_o = (state_q == ST_START) || (state_q == ST_DATA);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            nss_o <= 1'b1;
        end else begin
            nss_o <= !bsy_o;
        end
    end

endmodule

`default_nettype wire

//--- verilog/spi_baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module spi_baud_timer import spi_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  spi_cfg_t    cfg_i,
    input  spi_strobe_t strobe_i,
    output spi_timer_t  timer_o
);

    logic [7:0] baud_cnt;
    logic [7:0] reload_val;
    logic [3:0] bit_cnt;

    // 2^(br+1)-1, br of 7 wraps to 255
    assign reload_val = 8'((9'd1 << ({1'b0, cfg_i.br} + 4'd1)) - 9'd1);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            baud_cnt <= '0;
        end else if (strobe_i.cnt_reload) begin
            baud_cnt <= reload_val;
        end else if (!timer_o.cnt_zero) begin
            baud_cnt <= baud_cnt - 8'd1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt <= '0;
        end else if (strobe_i.tx_load) begin
            bit_cnt <= cfg_i.dff ? 4'd15 : 4'd7;
        end else if (strobe_i.sck_en && timer_o.cnt_zero && !timer_o.bit_zero) begin
            bit_cnt <= bit_cnt - 4'd1;
        end
    end

    assign timer_o.cnt_zero  = (baud_cnt == 8'd0);
    assign timer_o.cnt_half  = (baud_cnt == (8'd1 << cfg_i.br));
    assign timer_o.bit_zero  = (bit_cnt == 4'd0);
    assign timer_o.sck_phase = baud_cnt[cfg_i.br];

endmodule

`default_nettype wire

//--- verilog/spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter import spi_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  spi_cfg_t    cfg_i,
    input  spi_strobe_t strobe_i,
    input  spi_timer_t  timer_i,
    input  logic [15:0] tx_word_i,
    input  logic        miso_i,
    output logic [15:0] rx_word_o,
    output logic        sclk_o,
    output logic        mosi_o
);

    logic [15:0] tx_sreg;
    logic [15:0] rx_sreg;
    logic        shift_rx_q;
    logic        clear_rx_q;
    logic        mosi_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx_sreg <= '0;
        end else if (strobe_i.tx_load) begin
            tx_sreg <= {tx_word_i[15:8] & {8{cfg_i.dff}}, tx_word_i[7:0]};
        end else if (strobe_i.shift_tx) begin
            if (cfg_i.lsbfirst) begin
                tx_sreg <= {1'b0, tx_sreg[15:1]};
            end else begin
                tx_sreg <= {tx_sreg[14:0], 1'b0};
            end
        end
    end

    // rx side runs one clk late to line up with the registered pins
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            shift_rx_q <= 1'b0;
            clear_rx_q <= 1'b0;
        end else begin
            shift_rx_q <= strobe_i.shift_rx;
            clear_rx_q <= strobe_i.rx_done;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rx_sreg <= '0;
        end else if (clear_rx_q) begin
            rx_sreg <= '0;
        end else if (shift_rx_q) begin
            case ({cfg_i.lsbfirst, cfg_i.dff})
                2'b00:   rx_sreg <= {8'h00, rx_sreg[6:0], miso_i};
                2'b01:   rx_sreg <= {rx_sreg[14:0], miso_i};
                2'b10:   rx_sreg <= {8'h00, miso_i, rx_sreg[7:1]};
                default: rx_sreg <= {miso_i, rx_sreg[15:1]};
            endcase
        end
    end

    always_comb begin
        case ({cfg_i.lsbfirst, cfg_i.dff})
            2'b00:   mosi_d = tx_sreg[7];
            2'b01:   mosi_d = tx_sreg[15];
            default: mosi_d = tx_sreg[0];
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sclk_o <= 1'b0;
            mosi_o <= 1'b0;
        end else begin
            sclk_o <= (timer_i.sck_phase && strobe_i.sck_en) ^ cfg_i.cpol;
            mosi_o <= mosi_d;
        end
    end

    assign rx_word_o = rx_sreg;

endmodule

`default_nettype wire

//--- verilog/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master import spi_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    output logic     sclk_o,
    output logic     nss_o,
    output logic     mosi_o,
    input  logic     miso_i,
    output logic     irq_o
);

    spi_cfg_t    cfg;
    spi_strobe_t strobe;
    spi_timer_t  timer;
    logic        txe;
    logic        bsy;
    logic [15:0] tx_word;
    logic [15:0] rx_word;

    spi_regs regs_i (
        .clk       (clk),
        .rstn      (rstn),
        .apb_req_i (apb_req_i),
        .apb_rsp_o (apb_rsp_o),
        .cfg_o     (cfg),
        .txe_o     (txe),
        .tx_word_o (tx_word),
        .strobe_i  (strobe),
        .bsy_i     (bsy),
        .rx_word_i (rx_word),
        .irq_o     (irq_o)
    );

    spi_fsm fsm_i (
        .clk      (clk),
        .rstn     (rstn),
        .cfg_i    (cfg),
        .txe_i    (txe),
        .timer_i  (timer),
        .strobe_o (strobe),
        .bsy_o    (bsy),
        .nss_o    (nss_o)
    );

    spi_baud_timer timer_i (
        .clk      (clk),
        .rstn     (rstn),
        .cfg_i    (cfg),
        .strobe_i (strobe),
        .timer_o  (timer)
    );

    spi_shifter shifter_i (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_i     (cfg),
        .strobe_i  (strobe),
        .timer_i   (timer),
        .tx_word_i (tx_word),
        .miso_i    (miso_i),
        .rx_word_o (rx_word),
        .sclk_o    (sclk_o),
        .mosi_o    (mosi_o)
    );

endmodule

`default_nettype wire

//--- bench/spi_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module spi_monitor (
    input  logic clk,
    input  logic rstn,
    input  logic sclk_i,
    input  logic nss_i,
    input  logic mosi_i,
    input  logic irq_i,
    input  logic txe_i,
    input  logic rxne_i,
    input  logic txeie_i,
    input  logic rxneie_i,
    input  logic cpol_i,
    input  logic cpha_i,
    input  logic lsb_i,
    input  logic dff_i,
    output logic miso_o
);

    logic [15:0] reply_q[$];
    logic [15:0] frame_q[$];
    logic [15:0] reply_cur;
    logic [15:0] frame_cur;
    logic        sclk_prev;
    logic        nss_prev;
    int          tx_cnt;
    int          rx_cnt;
    int          checks;
    int          errors;
    int          test_base;
    int          nss_rises;

    initial begin
        miso_o    = 1'b0;
        reply_cur = '0;
        frame_cur = '0;
        sclk_prev = 1'b0;
        nss_prev  = 1'b1;
        tx_cnt    = 0;
        rx_cnt    = 0;
        checks    = 0;
        errors    = 0;
        test_base = 0;
        nss_rises = 0;
    end

    function int width();
        return dff_i ? 16 : 8;
    endfunction

    // bit number i of a frame in wire order
    function logic wire_bit(logic [15:0] w, int i);
        return lsb_i ? w[i] : w[width() - 1 - i];
    endfunction

    task push_reply(logic [15:0] w);
        reply_q.push_back(w);
    endtask

    task drive_next();
        if (tx_cnt == 0) begin
            reply_cur = (reply_q.size() > 0) ? reply_q.pop_front() : 16'h0000;
        end
        miso_o = wire_bit(reply_cur, tx_cnt);
        tx_cnt = (tx_cnt + 1) % width();
    endtask

    task capture();
        int idx;
        idx = lsb_i ? rx_cnt : width() - 1 - rx_cnt;
        frame_cur[idx] = mosi_i;
        rx_cnt++;
        if (rx_cnt == width()) begin
            frame_q.push_back(frame_cur);
            frame_cur = '0;
            rx_cnt    = 0;
        end
    endtask

    task check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task report_failure(string what);
        checks++;
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task check_frame(logic [15:0] exp);
        if (frame_q.size() == 0) begin
            report_failure("no MOSI frame was captured");
        end else begin
            check_value("mosi_o frame", {16'h0000, frame_q.pop_front()}, {16'h0000, exp});
        end
    endtask

    task finish_test(string name);
        int n;
        n = errors - test_base;
        if (n == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, n);
        end
        test_base = errors;
    endtask

    // pins are looked at mid cycle, miso changes there too
    always @(negedge clk) begin : watch
        logic lead;
        logic irq_exp;
        if (!rstn) begin
            tx_cnt    = 0;
            rx_cnt    = 0;
            frame_cur = '0;
        end else begin
            if (!nss_prev && nss_i) begin
                nss_rises++;
                tx_cnt    = 0;
                rx_cnt    = 0;
                frame_cur = '0;
            end
            // cpha 0 puts the first bit out before any edge
            if (nss_prev && !nss_i && !cpha_i) begin
                drive_next();
            end
            if (!nss_i && sclk_i != sclk_prev) begin
                lead = (sclk_i != cpol_i);
                if (lead != cpha_i) begin
                    capture();
                end else if (cpha_i || tx_cnt != 0) begin
                    drive_next();
                end
            end
            irq_exp = (txeie_i && txe_i) || (rxneie_i && rxne_i);
            check_value("irq_o", {31'h0, irq_i}, {31'h0, irq_exp});
        end
        sclk_prev = sclk_i;
        nss_prev  = nss_i;
    end

endmodule

`default_nettype wire

//--- bench/spi_chk.sv
`timescale 1ns/1ps
`default_nettype none

module spi_chk (
    input logic clk,
    input logic rstn,
    input logic nss,
    input logic sclk,
    input logic cpol,
    input logic tx_load,
    input logic rx_done,
    input logic txe
);

    int fails = 0;

    // a frame with nothing queued behind it releases nss
    assert property (@(posedge clk) disable iff (!rstn) rx_done && !tx_load |-> ##2 nss)
        else begin
            fails++;
            $error("NSS still low after the last frame ended");
        end

    // the load takes a full buffer and leaves it empty
    assert property (@(posedge clk) disable iff (!rstn) tx_load |-> !txe ##1 txe)
        else begin
            fails++;
            $error("frame load did not move a full TX buffer");
        end

    // idle sck sits at cpol
    assert property (@(posedge clk) disable iff (!rstn) nss |-> sclk == $past(cpol))
        else begin
            fails++;
            $error("SCK moved while NSS was high");
        end

endmodule

bind spi_master spi_chk chk_i (
    .clk     (clk),
    .rstn    (rstn),
    .nss     (nss_o),
    .sclk    (sclk_o),
    .cpol    (cfg.cpol),
    .tx_load (strobe.tx_load),
    .rx_done (strobe.rx_done),
    .txe     (txe)
);

`default_nettype wire

//--- bench/spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_tb import spi_pkg::*;;

    typedef struct packed {
        logic        cpol;
        logic        cpha;
        logic        lsb;
        logic        dff;
        logic [2:0]  br;
        logic [15:0] tx;
        logic [15:0] rx;
    } row_t;

    logic     clk;
    logic     rstn;
    logic     miso;
    logic     sclk;
    logic     nss;
    logic     mosi;
    logic     irq;
    apb_req_t req;
    apb_rsp_t rsp;
    logic     cur_cpol;
    logic     cur_cpha;
    logic     cur_lsb;
    logic     cur_dff;
    logic     txeie_exp;
    logic     rxneie_exp;
    row_t     rows [6];

    spi_master dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .apb_req_i (req),
        .apb_rsp_o (rsp),
        .sclk_o    (sclk),
        .nss_o     (nss),
        .mosi_o    (mosi),
        .miso_i    (miso),
        .irq_o     (irq)
    );

    spi_monitor mon_i (
        .clk      (clk),
        .rstn     (rstn),
        .sclk_i   (sclk),
        .nss_i    (nss),
        .mosi_i   (mosi),
        .irq_i    (irq),
        .txe_i    (dut_i.txe),
        .rxne_i   (dut_i.regs_i.rxne_q),
        .txeie_i  (txeie_exp),
        .rxneie_i (rxneie_exp),
        .cpol_i   (cur_cpol),
        .cpha_i   (cur_cpha),
        .lsb_i    (cur_lsb),
        .dff_i    (cur_dff),
        .miso_o   (miso)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task apb_write(logic [11:0] addr, logic [31:0] data);
        @(negedge clk);
        req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        // CR2 enables take effect on the setup edge
        if (addr == ADDR_CR2) begin
            txeie_exp  = data[7];
            rxneie_exp = data[6];
        end
        @(negedge clk);
        req.penable = 1'b1;
        @(negedge clk);
        req = '0;
    endtask

    task apb_read(logic [11:0] addr, output logic [31:0] data);
        @(negedge clk);
        req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
        @(negedge clk);
        req.penable = 1'b1;
        data = rsp.prdata;
        @(negedge clk);
        req = '0;
    endtask

    task read_check(logic [11:0] addr, logic [31:0] exp, string name);
        logic [31:0] data;
        apb_read(addr, data);
        mon_i.check_value(name, data, exp);
    endtask

    task poll_sr(logic [31:0] mask, logic [31:0] value, string what);
        logic [31:0] sr;
        logic        hit;
        int          n;
        hit = 1'b0;
        for (n = 0; n < 3000 && !hit; n++) begin
            apb_read(ADDR_SR, sr);
            hit = ((sr & mask) == value);
        end
        if (!hit) begin
            mon_i.report_failure({"timed out waiting for ", what});
        end
    endtask

    // CR1 has cpha at bit 0, cpol 1, br 5:3, spe 6, lsbfirst 7, dff 11
    function logic [31:0] cr1_word(logic cpha, logic cpol, logic [2:0] br, logic spe,
                                   logic lsb, logic dff);
        return {20'h0, dff, 3'b000, lsb, spe, br, 1'b0, cpol, cpha};
    endfunction

    task set_mode(row_t r);
        apb_write(ADDR_CR1, cr1_word(r.cpha, r.cpol, r.br, 1'b0, r.lsb, r.dff));
        cur_cpol = r.cpol;
        cur_cpha = r.cpha;
        cur_lsb  = r.lsb;
        cur_dff  = r.dff;
        apb_write(ADDR_CR1, cr1_word(r.cpha, r.cpol, r.br, 1'b1, r.lsb, r.dff));
    endtask

    task run_frame(row_t r);
        logic [15:0] mask;
        mask = r.dff ? 16'hFFFF : 16'h00FF;
        set_mode(r);
        mon_i.push_reply(r.rx & mask);
        apb_write(ADDR_DR, {16'h0, r.tx});
        poll_sr(32'h80, 32'h80, "BSY to rise");
        poll_sr(32'h82, 32'h02, "end of frame");
        read_check(ADDR_SR, 32'h3, "SR after frame");
        mon_i.check_frame(r.tx & mask);
        read_check(ADDR_DR, {16'h0, r.rx & mask}, "DR");
        read_check(ADDR_SR, 32'h1, "SR after DR read");
    endtask

    task back_to_back();
        row_t r;
        int   base;
        r = '{cpol: 1'b0, cpha: 1'b1, lsb: 1'b0, dff: 1'b0, br: 3'd3,
              tx: 16'h00A5, rx: 16'h005A};
        set_mode(r);
        base = mon_i.nss_rises;
        mon_i.push_reply(16'h005A);
        mon_i.push_reply(16'h00C3);
        apb_write(ADDR_DR, 32'h00A5);
        poll_sr(32'h01, 32'h01, "TXE after first load");
        apb_write(ADDR_DR, 32'h003C);
        // dropped since the buffer is still full
        apb_write(ADDR_DR, 32'h00FF);
        poll_sr(32'h83, 32'h03, "end of both frames");
        mon_i.check_frame(16'h00A5);
        mon_i.check_frame(16'h003C);
        mon_i.check_value("extra MOSI frames", mon_i.frame_q.size(), 0);
        read_check(ADDR_DR, 32'h00C3, "DR");
        mon_i.check_value("NSS rising edges", mon_i.nss_rises - base, 1);
    endtask

    initial begin
        int i;
        int fails;
        req        = '0;
        rstn       = 1'b0;
        cur_cpol   = 1'b0;
        cur_cpha   = 1'b0;
        cur_lsb    = 1'b0;
        cur_dff    = 1'b0;
        txeie_exp  = 1'b0;
        rxneie_exp = 1'b0;
        rows[0] = '{1'b0, 1'b0, 1'b0, 1'b0, 3'd1, 16'h00A5, 16'h003C};
        rows[1] = '{1'b1, 1'b0, 1'b0, 1'b0, 3'd2, 16'h1234, 16'h00C9};
        rows[2] = '{1'b0, 1'b1, 1'b1, 1'b0, 3'd1, 16'h0081, 16'h007E};
        rows[3] = '{1'b1, 1'b1, 1'b0, 1'b1, 3'd0, 16'hBEEF, 16'h5AC3};
        rows[4] = '{1'b0, 1'b0, 1'b1, 1'b1, 3'd3, 16'hC001, 16'h9E37};
        rows[5] = '{1'b1, 1'b1, 1'b1, 1'b1, 3'd2, 16'h7F10, 16'h0FF0};
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        read_check(ADDR_CR1, 32'h4, "CR1 reset");
        read_check(ADDR_CR2, 32'h0, "CR2 reset");
        read_check(ADDR_SR, 32'h1, "SR reset");
        mon_i.check_value("irq_o", {31'h0, irq}, 32'h0);
        mon_i.finish_test("reset values");

        apb_write(ADDR_CR1, cr1_word(1'b1, 1'b1, 3'd5, 1'b0, 1'b1, 1'b1));
        read_check(ADDR_CR1, cr1_word(1'b1, 1'b1, 3'd5, 1'b0, 1'b1, 1'b1) | 32'h4, "CR1");
        apb_write(ADDR_CR1, cr1_word(1'b1, 1'b1, 3'd5, 1'b1, 1'b1, 1'b1));
        read_check(ADDR_CR1, cr1_word(1'b1, 1'b1, 3'd5, 1'b1, 1'b1, 1'b1) | 32'h4, "CR1");
        // format fields hold while enabled
        apb_write(ADDR_CR1, cr1_word(1'b0, 1'b0, 3'd2, 1'b1, 1'b0, 1'b0));
        read_check(ADDR_CR1, cr1_word(1'b0, 1'b0, 3'd5, 1'b1, 1'b1, 1'b1) | 32'h4, "CR1");
        apb_write(ADDR_CR1, 32'h0);
        apb_write(ADDR_CR2, 32'hC0);
        read_check(ADDR_CR2, 32'hC0, "CR2");
        apb_write(ADDR_CR2, 32'hFFFF_FFFF);
        read_check(ADDR_CR2, 32'hC0, "CR2");
        apb_write(ADDR_CR2, 32'h40);
        mon_i.finish_test("register access");

        for (i = 0; i < 6; i++) begin
            run_frame(rows[i]);
            mon_i.finish_test($sformatf("frame row %0d", i));
        end

        back_to_back();
        mon_i.finish_test("back to back frames");

        fails = dut_i.chk_i.fails;
        $display("%0d checks, %0d errors, %0d assertion failures",
                 mon_i.checks, mon_i.errors, fails);
        if (mon_i.errors == 0 && fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/spi_pkg.sv
verilog/spi_regs.sv
verilog/spi_fsm.sv
verilog/spi_baud_timer.sv
verilog/spi_shifter.sv
verilog/spi_master.sv
bench/spi_monitor.sv
bench/spi_chk.sv
bench/spi_tb.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  - verilog/spi_pkg.sv
  - verilog/spi_regs.sv
  - verilog/spi_fsm.sv
  - verilog/spi_baud_timer.sv
  - verilog/spi_shifter.sv
  - verilog/spi_master.sv
  - target: simulation
    files:
      - bench/spi_monitor.sv
      - bench/spi_chk.sv
      - bench/spi_tb.sv
